/* cordic_macros.svh */
//==========================================================================
// CORDIC sine/cosine widths and constants
// Angle and result width, guard bits, iteration count, start vector
//==========================================================================

`ifndef CORDIC_MACROS_SVH
`define CORDIC_MACROS_SVH

// Angle and result width, angle LSB is pi/2^(W-1)
`define CORDIC_W 16

// Extra LSBs carried on the internal x, y and z registers
`define CORDIC_GUARD 2

// Internal datapath width
`define CORDIC_IW (`CORDIC_W + `CORDIC_GUARD)

// Micro-rotations per request and width of their counter
`define CORDIC_ITER 14
`define CORDIC_ITER_BITS 4

// Start x, inverse CORDIC gain 0.6072529350 with 1.0 at 2^(W-2+GUARD)
`define CORDIC_X0 39797

`endif

/* cordic_pkg.sv */
//==========================================================================
// CORDIC sine/cosine shared types
// Operation select and rotator controller state encodings
//==========================================================================

package cordic_pkg;

   //========================================================================
   // Operation select
   //========================================================================

   // Same encoding as the operation bit of the quadrant decoder
   typedef enum logic {
      OP_COS = 1'b0,
      OP_SIN = 1'b1
   } cordic_op_e;

   //========================================================================
   // Rotator controller states
   //========================================================================

   // ST_DONE lasts one cycle and flags the final x and y values
   typedef enum logic [1:0] {
      ST_IDLE   = 2'd0,
      ST_ROTATE = 2'd1,
      ST_DONE   = 2'd2
   } rot_state_e;

endpackage : cordic_pkg

/* cordic_atan_rom.sv */
//==========================================================================
// CORDIC arctangent table
// atan(2^-i) in internal angle units, pi equal to 2^(W-1+GUARD)
//==========================================================================
`timescale 1ns/10ps
`include "cordic_macros.svh"

module cordic_atan_rom (
   input  logic [`CORDIC_ITER_BITS-1:0] index_i,
   output logic [`CORDIC_IW-1:0]        atan_o
);

   localparam int IW = `CORDIC_IW;

   // Rounded to nearest, entry 0 is exactly pi/4
   always_comb begin
      case (index_i)
         4'd0:    atan_o = IW'(32768);
         4'd1:    atan_o = IW'(19344);
         4'd2:    atan_o = IW'(10221);
         4'd3:    atan_o = IW'(5188);
         4'd4:    atan_o = IW'(2604);
         4'd5:    atan_o = IW'(1303);
         4'd6:    atan_o = IW'(652);
         4'd7:    atan_o = IW'(326);
         4'd8:    atan_o = IW'(163);
         4'd9:    atan_o = IW'(81);
         4'd10:   atan_o = IW'(41);
         4'd11:   atan_o = IW'(20);
         4'd12:   atan_o = IW'(10);
         4'd13:   atan_o = IW'(5);
         // Past the last micro-rotation
         default: atan_o = '0;
      endcase
   end

endmodule : cordic_atan_rom

/* cordic_range_reduce.sv */
//==========================================================================
// CORDIC range reduction
// Samples a request, extracts the region flag and folds the angle
// into [-pi/2, pi/2) for the rotator
//==========================================================================
`timescale 1ns/10ps
`include "cordic_macros.svh"

module cordic_range_reduce (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  logic                   start_i,
   input  logic [`CORDIC_W-1:0]   angle_i,
   input  logic                   operation_i,
   input  logic                   busy_i,
   output logic [1:0]             shift_region_flag_o,
   output cordic_pkg::cordic_op_e operation_o,
   output logic [`CORDIC_W-1:0]   residual_o,
   output logic                   load_o
);

   localparam int W = `CORDIC_W;

   logic         accept;
   logic [W-1:0] residual_d;

   // Requests while the rotator is busy are dropped
   assign accept = start_i && !busy_i;

   // Copy bit W-1 into bit W-2
   // Region 01 loses pi/2, region 10 gains pi/2, 00 and 11 pass
   assign residual_d = {angle_i[W-1], angle_i[W-1], angle_i[W-3:0]};

   // Request fields, held until the next accepted start
   always_ff @(posedge clk_i) begin
      if (accept) begin
         shift_region_flag_o <= angle_i[W-1:W-2];
         operation_o         <= cordic_pkg::cordic_op_e'(operation_i);
         residual_o          <= residual_d;
      end
   end

   // Pending load, one cycle after the accepted start
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         load_o <= 1'b0;
      end else begin
         load_o <= accept;
      end
   end

   // Rotator busy must already refuse a start while a load is pending
   a_load_single : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      load_o |=> !load_o);

endmodule : cordic_range_reduce

/* cordic_rotator.sv */
//==========================================================================
// CORDIC rotation engine
// One micro-rotation per cycle drives z to zero, leaving cos and sin
// of the residual angle in x and y
//==========================================================================
`timescale 1ns/10ps
`include "cordic_macros.svh"

module cordic_rotator (
   input  logic                         clk_i,
   input  logic                         rst_n_i,
   input  logic                         load_i,
   input  logic        [`CORDIC_W-1:0]  residual_i,
   output logic signed [`CORDIC_IW-1:0] x_o,
   output logic signed [`CORDIC_IW-1:0] y_o,
   output logic                         busy_o,
   output logic                         rot_done_o
);

   localparam int IW   = `CORDIC_IW;
   localparam int ITER = `CORDIC_ITER;

   cordic_pkg::rot_state_e state_q;

   // Iteration number, also the shift amount and table index
   logic [`CORDIC_ITER_BITS-1:0] cnt_q;

   logic signed [IW-1:0] x_q;
   logic signed [IW-1:0] y_q;
   logic signed [IW-1:0] z_q;
   logic signed [IW-1:0] x_d;
   logic signed [IW-1:0] y_d;
   logic signed [IW-1:0] z_d;
   logic signed [IW-1:0] x_sh;
   logic signed [IW-1:0] y_sh;
   logic        [IW-1:0] atan;
   logic                 start_rot;

   cordic_atan_rom u_atan_rom (
      .index_i (cnt_q),
      .atan_o  (atan)
   );

   assign start_rot = (state_q == cordic_pkg::ST_IDLE) && load_i;

   //========================================================================
   // Controller
   //========================================================================

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q <= cordic_pkg::ST_IDLE;
         cnt_q   <= '0;
      end else begin
         case (state_q)
            cordic_pkg::ST_IDLE: begin
               if (load_i) begin
                  state_q <= cordic_pkg::ST_ROTATE;
                  cnt_q   <= '0;
               end
            end
            cordic_pkg::ST_ROTATE: begin
               cnt_q <= cnt_q + 1'b1;
               // Last micro-rotation lands on this edge
               if (cnt_q == `CORDIC_ITER_BITS'(ITER - 1)) begin
                  state_q <= cordic_pkg::ST_DONE;
               end
            end
            cordic_pkg::ST_DONE: begin
               state_q <= cordic_pkg::ST_IDLE;
            end
            default: begin
               state_q <= cordic_pkg::ST_IDLE;
            end
         endcase
      end
   end

   //========================================================================
   // Micro-rotation datapath
   //========================================================================

   assign x_sh = x_q >>> cnt_q;
   assign y_sh = y_q >>> cnt_q;

   // Rotate toward z = 0, direction from the sign of z
   always_comb begin
      if (!z_q[IW-1]) begin
         x_d = x_q - y_sh;
         y_d = y_q + x_sh;
         z_d = z_q - $signed(atan);
      end else begin
         x_d = x_q + y_sh;
         y_d = y_q - x_sh;
         z_d = z_q + $signed(atan);
      end
   end

   // x starts at the inverse gain so the loop needs no final scaling
   always_ff @(posedge clk_i) begin
      if (start_rot) begin
         x_q <= IW'(`CORDIC_X0);
         y_q <= '0;
         z_q <= {residual_i, {`CORDIC_GUARD{1'b0}}};
      end else if (state_q == cordic_pkg::ST_ROTATE) begin
         x_q <= x_d;
         y_q <= y_d;
         z_q <= z_d;
      end
   end

   assign x_o        = x_q;
   assign y_o        = y_q;
   // Pending load counts as busy so a second start is refused at once
   assign busy_o     = (state_q != cordic_pkg::ST_IDLE) || load_i;
   assign rot_done_o = (state_q == cordic_pkg::ST_DONE);

   // Range stage must hold off new loads while a rotation runs
   a_load_when_idle : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      load_i |-> (state_q == cordic_pkg::ST_IDLE));

   a_cnt_in_range : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (state_q == cordic_pkg::ST_ROTATE) |-> (cnt_q < `CORDIC_ITER_BITS'(ITER)));

endmodule : cordic_rotator

/* cordic_quadrant_deco.sv */
//==========================================================================
// CORDIC quadrant decoder
// Picks the x or y result and flips the sign bit per region and
// operation, on a sign-magnitude word
//==========================================================================
`timescale 1ns/10ps
`include "cordic_macros.svh"

module cordic_quadrant_deco (
   input  logic [`CORDIC_W-1:0]   data_i,
   input  cordic_pkg::cordic_op_e operation_i,
   input  logic [1:0]             shift_region_flag_i,
   output logic                   sel_mux_3_o,
   output logic [`CORDIC_W-1:0]   data_o
);

   localparam int W = `CORDIC_W;

   logic [W-1:0] data_neg;

   // Negation of a sign-magnitude word
   assign data_neg = {~data_i[W-1], data_i[W-2:0]};

   // sel_mux_3_o low takes x, high takes y
   always_comb begin
      sel_mux_3_o = 1'b0;
      data_o      = data_i;
      if (operation_i == cordic_pkg::OP_COS) begin
         case (shift_region_flag_i)
            2'b00: sel_mux_3_o = 1'b0;
            // cos(r + pi/2) = -sin(r)
            2'b01: begin
               sel_mux_3_o = 1'b1;
               data_o      = data_neg;
            end
            // cos(r - pi/2) = sin(r)
            2'b10: sel_mux_3_o = 1'b1;
            default: sel_mux_3_o = 1'b0;
         endcase
      end else begin
         case (shift_region_flag_i)
            2'b00: sel_mux_3_o = 1'b1;
            // sin(r + pi/2) = cos(r)
            2'b01: sel_mux_3_o = 1'b0;
            // sin(r - pi/2) = -cos(r)
            2'b10: begin
               sel_mux_3_o = 1'b0;
               data_o      = data_neg;
            end
            default: sel_mux_3_o = 1'b1;
         endcase
      end
   end

endmodule : cordic_quadrant_deco

/* cordic_output_stage.sv */
//==========================================================================
// CORDIC output stage
// Selects x or y, drops the guard bits, converts to saturated
// sign-magnitude and registers the result with the done pulse
//==========================================================================
`timescale 1ns/10ps
`include "cordic_macros.svh"

module cordic_output_stage (
   input  logic                         clk_i,
   input  logic                         rst_n_i,
   input  logic                         rot_done_i,
   input  logic signed [`CORDIC_IW-1:0] x_i,
   input  logic signed [`CORDIC_IW-1:0] y_i,
   input  cordic_pkg::cordic_op_e       operation_i,
   input  logic [1:0]                   shift_region_flag_i,
   output logic [`CORDIC_W-1:0]         result_o,
   output logic                         done_o
);

   localparam int W  = `CORDIC_W;
   localparam int IW = `CORDIC_IW;

   logic                sel_mux_3;
   logic signed [IW-1:0] xy_sel;
   logic signed [W-1:0] xy_trunc;
   logic        [W-1:0] mag_full;
   logic        [W-2:0] mag_sat;
   logic        [W-1:0] sm_word;
   logic        [W-1:0] sm_deco;

   // Third mux, steered by the decoder
   assign xy_sel = sel_mux_3 ? y_i : x_i;

   // Arithmetic shift by the guard bits, truncating toward minus infinity
   assign xy_trunc = xy_sel[IW-1:`CORDIC_GUARD];

   // Magnitude, only the most negative value overflows W-1 bits
   assign mag_full = xy_trunc[W-1] ? W'(-xy_trunc) : W'(xy_trunc);
   assign mag_sat  = mag_full[W-1] ? {(W-1){1'b1}} : mag_full[W-2:0];
   assign sm_word  = {xy_trunc[W-1], mag_sat};

   cordic_quadrant_deco u_quadrant_deco (
      .data_i              (sm_word),
      .operation_i         (operation_i),
      .shift_region_flag_i (shift_region_flag_i),
      .sel_mux_3_o         (sel_mux_3),
      .data_o              (sm_deco)
   );

   // Result held until the next rotation completes
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         result_o <= '0;
         done_o   <= 1'b0;
      end else begin
         done_o <= rot_done_i;
         if (rot_done_i) begin
            result_o <= sm_deco;
         end
      end
   end

   // One done pulse per request
   a_done_single : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      done_o |=> !done_o);

endmodule : cordic_output_stage

/* cordic_sincos_top.sv */
//==========================================================================
// CORDIC sine/cosine unit
// Start pulse in, done pulse and sign-magnitude result out after
// range reduction, iterative rotation and output decoding
//==========================================================================
`timescale 1ns/10ps
`include "cordic_macros.svh"

module cordic_sincos_top (
   input  logic                 clk_i,
   input  logic                 rst_n_i,
   input  logic                 start_i,
   input  logic                 operation_i,
   input  logic [`CORDIC_W-1:0] angle_i,
   output logic [`CORDIC_W-1:0] result_o,
   output logic                 busy_o,
   output logic                 done_o
);

   logic [1:0]                   shift_region_flag;
   cordic_pkg::cordic_op_e       operation;
   logic        [`CORDIC_W-1:0]  residual;
   logic                         load;
   logic signed [`CORDIC_IW-1:0] x_res;
   logic signed [`CORDIC_IW-1:0] y_res;
   logic                         rot_busy;
   logic                         rot_done;

   //========================================================================
   // Request capture and angle folding
   //========================================================================

   cordic_range_reduce u_range_reduce (
      .clk_i               (clk_i),
      .rst_n_i             (rst_n_i),
      .start_i             (start_i),
      .angle_i             (angle_i),
      .operation_i         (operation_i),
      .busy_i              (rot_busy),
      .shift_region_flag_o (shift_region_flag),
      .operation_o         (operation),
      .residual_o          (residual),
      .load_o              (load)
   );

   // Busy covers the pending load and the whole rotation
   cordic_rotator u_rotator (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .load_i     (load),
      .residual_i (residual),
      .x_o        (x_res),
      .y_o        (y_res),
      .busy_o     (rot_busy),
      .rot_done_o (rot_done)
   );

   cordic_output_stage u_output_stage (
      .clk_i               (clk_i),
      .rst_n_i             (rst_n_i),
      .rot_done_i          (rot_done),
      .x_i                 (x_res),
      .y_i                 (y_res),
      .operation_i         (operation),
      .shift_region_flag_i (shift_region_flag),
      .result_o            (result_o),
      .done_o              (done_o)
   );

   assign busy_o = rot_busy;

endmodule : cordic_sincos_top

/* tb_cordic_sincos.sv */
//==========================================================================
// CORDIC sine/cosine unit testbench
// Drives requests into the unit and checks every result against a
// bit-exact model of the CORDIC flow and against $sin and $cos
//==========================================================================
`timescale 1ns/10ps
`include "cordic_macros.svh"

module tb_cordic_sincos;

   localparam int  W          = `CORDIC_W;
   localparam int  G          = `CORDIC_GUARD;
   localparam int  IW         = `CORDIC_IW;
   localparam int  ITER       = `CORDIC_ITER;
   localparam int  LATENCY    = ITER + 3;
   localparam int  N_RANDOM   = 500;
   localparam int  N_REQUESTS = 16 + 2 + N_RANDOM;
   // 600 requests of at most 20 cycles, plus reset and margin
   localparam int  MAX_CYCLES = 600 * 20 + 200;
   localparam real PI         = 3.14159265358979323846;
   localparam real TOL        = 1.0 / 1024.0;

   logic         clk_i;
   logic         rst_n_i;
   logic         start_i;
   logic         operation_i;
   logic [W-1:0] angle_i;
   logic [W-1:0] result_o;
   logic         busy_o;
   logic         done_o;

   // Outstanding requests as {operation, angle}
   logic [W:0]   pending[$];
   logic [W:0]   req;
   int           checked;
   int           cycle_cnt;
   real          err;

   cordic_sincos_top UUT (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .start_i     (start_i),
      .operation_i (operation_i),
      .angle_i     (angle_i),
      .result_o    (result_o),
      .busy_o      (busy_o),
      .done_o      (done_o)
   );

   // 10 ns clock
   always #5 clk_i = ~clk_i;

   //========================================================================
   // Failure reporting and checks
   //========================================================================

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("Finished with errors");
      $fatal(1, "Simulation stopped at first error");
   endtask

   task automatic compare(input string name, input logic [31:0] got,
                          input logic [31:0] exp);
      if (got !== exp) begin
         abort_run($sformatf("CHECK FAILED: %s got 0x%0h expected 0x%0h",
                             name, got, exp));
      end
   endtask

   //========================================================================
   // Reference model
   //========================================================================

   // Fold, rotate, truncate, saturate and decode exactly as the unit does
   function automatic logic [W-1:0] cordic_ref(input logic [W-1:0] angle,
                                               input logic op);
      logic [W-1:0]         res;
      logic signed [IW-1:0] x;
      logic signed [IW-1:0] y;
      logic signed [IW-1:0] z;
      logic signed [IW-1:0] x_nx;
      logic signed [IW-1:0] y_nx;
      logic signed [IW-1:0] atan_i;
      logic signed [IW-1:0] picked;
      logic signed [W-1:0]  trunc;
      logic                 sel_y;
      logic                 invert;
      logic                 sign;
      int                   mag;
      int                   i;
      // Residual in [-pi/2, pi/2), a quarter turn removed or added by region
      case (angle[W-1:W-2])
         2'b01:   res = angle - W'(2 ** (W - 2));
         2'b10:   res = angle + W'(2 ** (W - 2));
         default: res = angle;
      endcase
      z = {res, {G{1'b0}}};
      x = IW'($rtoi(0.6072529350 * (2.0 ** (W - 2 + G)) + 0.5));
      y = '0;
      for (i = 0; i < ITER; i++) begin
         atan_i = IW'($rtoi($atan(2.0 ** (-i)) * (2.0 ** (W - 1 + G)) / PI + 0.5));
         if (z >= 0) begin
            x_nx = x - (y >>> i);
            y_nx = y + (x >>> i);
            z    = z - atan_i;
         end else begin
            x_nx = x + (y >>> i);
            y_nx = y - (x >>> i);
            z    = z + atan_i;
         end
         x = x_nx;
         y = y_nx;
      end
      // Decoder table, {operation, region}
      case ({op, angle[W-1:W-2]})
         3'b000:  {sel_y, invert} = 2'b00;
         3'b001:  {sel_y, invert} = 2'b11;
         3'b010:  {sel_y, invert} = 2'b10;
         3'b011:  {sel_y, invert} = 2'b00;
         3'b100:  {sel_y, invert} = 2'b10;
         3'b101:  {sel_y, invert} = 2'b00;
         3'b110:  {sel_y, invert} = 2'b01;
         default: {sel_y, invert} = 2'b10;
      endcase
      picked = sel_y ? y : x;
      trunc  = W'(picked >>> G);
      mag    = (trunc < 0) ? -int'(trunc) : int'(trunc);
      if (mag > (2 ** (W - 1)) - 1) begin
         mag = (2 ** (W - 1)) - 1;
      end
      sign = (trunc < 0) ^ invert;
      return {sign, mag[W-2:0]};
   endfunction

   // Real value of a sign-magnitude result, 1.0 at 2^(W-2)
   function automatic real sm_to_real(input logic [W-1:0] word);
      real mag;
      mag = $itor(word[W-2:0]) / (2.0 ** (W - 2));
      return word[W-1] ? -mag : mag;
   endfunction

   function automatic real math_ref(input logic [W-1:0] angle, input logic op);
      real th;
      th = $itor($signed(angle)) * PI / (2.0 ** (W - 1));
      return op ? $sin(th) : $cos(th);
   endfunction

   //========================================================================
   // Result monitor
   //========================================================================

   always @(negedge clk_i) begin
      if (rst_n_i && done_o) begin
         if (pending.size() == 0) begin
            abort_run("done_o pulsed with no request outstanding");
         end else begin
            req = pending.pop_front();
            compare("result_o", 32'(result_o), 32'(cordic_ref(req[W-1:0], req[W])));
            err = sm_to_real(result_o) - math_ref(req[W-1:0], req[W]);
            if (err > TOL || err < -TOL) begin
               abort_run($sformatf(
                  "CHECK FAILED: result_o 0x%0h beyond 2^-10 for angle 0x%0h op %0d",
                  result_o, req[W-1:0], req[W]));
            end
            checked++;
         end
      end
   end

   // Run length guard
   always @(posedge clk_i) begin
      cycle_cnt++;
      if (cycle_cnt >= MAX_CYCLES) begin
         abort_run("Timeout, the run went past its cycle limit");
      end
   end

   //========================================================================
   // Stimulus
   //========================================================================

   // One request, checks latency, busy_o and that result_o holds meanwhile
   // A second start in mid-flight must be dropped by the unit
   task automatic run_request(input logic [W-1:0] angle, input logic op,
                              input bit extra_start);
      int           n;
      logic [W-1:0] held;
      @(negedge clk_i);
      held        = result_o;
      start_i     = 1'b1;
      angle_i     = angle;
      operation_i = op;
      pending.push_back({op, angle});
      n = 0;
      do begin
         @(negedge clk_i);
         n++;
         start_i     = extra_start && (n == 4);
         angle_i     = start_i ? ~angle : angle;
         operation_i = start_i ? ~op : op;
         if (!done_o) begin
            compare("busy_o", 32'(busy_o), 32'd1);
            compare("result_o held", 32'(result_o), 32'(held));
         end
      end while (!done_o && n <= LATENCY);
      compare("done_o latency", 32'(n), 32'(LATENCY));
      @(negedge clk_i);
      compare("done_o width", 32'(done_o), 32'd0);
   endtask

   initial begin
      logic [W-1:0] angle;
      logic         op;
      int           k;
      clk_i       = 1'b0;
      rst_n_i     = 1'b0;
      start_i     = 1'b0;
      operation_i = 1'b0;
      angle_i     = '0;
      checked     = 0;
      cycle_cnt   = 0;
      void'($urandom(32'hcbf2d0ca));

      repeat (10) @(negedge clk_i);
      rst_n_i = 1'b1;
      @(negedge clk_i);
      compare("busy_o after reset", 32'(busy_o), 32'd0);
      compare("done_o after reset", 32'(done_o), 32'd0);
      compare("result_o after reset", 32'(result_o), 32'd0);

      // Region boundaries and mid-points, both operations
      for (k = 0; k < 16; k++) begin
         angle = W'(k[2:0]) << (W - 3);
         run_request(angle, k[3], 1'b0);
      end

      // Starts during busy
      run_request(16'h3a51, 1'b0, 1'b1);
      run_request(16'hb7c2, 1'b1, 1'b1);

      for (k = 0; k < N_RANDOM; k++) begin
         angle = W'($urandom());
         op    = 1'($urandom());
         run_request(angle, op, 1'b0);
      end

      // Room for a stray done_o to show up
      repeat (4) @(negedge clk_i);
      compare("requests checked", 32'(checked), 32'(N_REQUESTS));
      if (pending.size() != 0) begin
         abort_run("Requests left without a done_o");
      end else begin
         $display("Finished with no errors");
         $finish;
      end
   end

endmodule : tb_cordic_sincos

/* build.f */
+incdir+.
cordic_pkg.sv
cordic_atan_rom.sv
cordic_range_reduce.sv
cordic_rotator.sv
cordic_quadrant_deco.sv
cordic_output_stage.sv
cordic_sincos_top.sv
tb_cordic_sincos.sv

/* Makefile */
# Verilator build and run of the CORDIC sine/cosine testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module tb_cordic_sincos -Mdir obj_dir
	./obj_dir/Vtb_cordic_sincos 2>&1 | tee sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log
